// File: Bender.yml
package:
  name: bk_top

sources:
  - common/bk_pkg.sv
  - src/bk_sequencer.sv
  - src/sector_counter.sv
  - backup_ram/bram_format.sv
  - backup_ram/backup_ram.sv
  - src/bk_top.sv
  - target: test
    files:
      - tests/tb_bk_top.sv

// File: backup_ram/backup_ram.sv
/*
 * Dual-width backup RAM, 2 KB shared by the console and the host link.
 * Port a is a byte port for the console, port b a word port for the host,
 * where word w holds byte 2w low and byte 2w+1 high. The format writer
 * takes over port b while it runs. Both read ports are registered.
 */

`timescale 1ns/100ps

module backup_ram import bk_pkg::*; (
	input  logic                         clk_sys,
	input  bram_port_t                   console,
	input  logic [BRAM_ADDR_W-2:0]       host_addr,
	input  logic [BUF_DATA_W-1:0]        host_din,
	input  logic                         host_we,
	input  logic                         fmt_active,
	input  logic [$clog2(HDR_WORDS)-1:0] fmt_addr,
	input  hdr_word_t                    fmt_data,
	output logic [BRAM_DATA_W-1:0]       bram_q,
	output logic [BUF_DATA_W-1:0]        host_q
);

	localparam int WORD_ADDR_W = BRAM_ADDR_W - 1;
	localparam int WORDS = 2 ** WORD_ADDR_W;

	// Two bytes per word, byte 0 in the low half
	typedef logic [1:0][BRAM_DATA_W-1:0] ram_word_t;

	ram_word_t mem [WORDS];

	logic [WORD_ADDR_W-1:0] addr_b;
	ram_word_t              din_b;
	logic                   we_b;

	logic [WORD_ADDR_W-1:0] console_word;
	logic                   console_byte;

	assign console_word = console.addr[BRAM_ADDR_W-1:1];
	assign console_byte = console.addr[0];

	////////////////////////////////////////
	// Port b source select
	////////////////////////////////////////

	// Format writes override the host
	always_comb begin
		if (fmt_active) begin
			addr_b = WORD_ADDR_W'(fmt_addr);
			din_b  = fmt_data;
			we_b   = 1'b1;
		end else begin
			addr_b = host_addr;
			din_b  = host_din;
			we_b   = host_we;
		end
	end

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (console.wr)
			mem[console_word][console_byte] <= console.data;
		if (we_b)
			mem[addr_b] <= din_b;

		// Read-before-write on both ports
		bram_q <= mem[console_word][console_byte];
		host_q <= mem[addr_b];
	end

endmodule

// File: backup_ram/bram_format.sv
/*
 * Format writer for the backup RAM.
 * A rising format command runs a short timer that presents each default
 * header word with its word address, one word per cycle. A new command
 * edge during a run starts it over from word 0.
 */

`timescale 1ns/100ps

module bram_format import bk_pkg::*; (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         cmd_format,
	output logic                         fmt_active,
	output logic [$clog2(HDR_WORDS)-1:0] fmt_addr,
	output hdr_word_t                    fmt_data
);

	// Top bit set means the timer is idle
	localparam int STEP_W = $clog2(HDR_WORDS) + 1;
	localparam logic [STEP_W-1:0] STEP_IDLE = STEP_W'(HDR_WORDS);

	logic [STEP_W-1:0] step;
	logic              old_format;
	logic              format_rise;

	assign format_rise = cmd_format & ~old_format;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_format <= 1'b0;
			step       <= STEP_IDLE;
		end else begin
			old_format <= cmd_format;
			if (format_rise)
				step <= '0;
			else if (!step[STEP_W-1])
				step <= step + STEP_W'(1);
		end
	end

	assign fmt_active = ~step[STEP_W-1];
	assign fmt_addr   = step[STEP_W-2:0];
	assign fmt_data   = default_header[step[STEP_W-2:0]];

endmodule

// File: common/bk_pkg.sv
/*
 * Shared definitions for the backup RAM save/load engine.
 * Holds the RAM and host link widths, the sector geometry, the default
 * header written by a format command and the packed port structs.
 * Modules pull it in with a wildcard import in their header.
 */

package bk_pkg;

	// Console side of the RAM
	parameter int BRAM_ADDR_W = 11;
	parameter int BRAM_DATA_W = 8;

	// Host storage link
	parameter int BUF_ADDR_W = 8;
	parameter int BUF_DATA_W = 16;
	parameter int LBA_W = 32;

	// Sector geometry inside the 2 KB RAM
	parameter int SECTOR_IDX_W = 2;
	parameter int N_SECTORS_DEF = 4;

	// Default header, "HUBM" followed by 0x00881080
	parameter int HDR_WORDS = 4;

	typedef logic [BUF_DATA_W-1:0] hdr_word_t;

	parameter hdr_word_t default_header [HDR_WORDS] = '{
		16'h5548,
		16'h4D42,
		16'h8800,
		16'h8010
	};

	// Byte access from the console CPU
	typedef struct packed {
		logic [BRAM_ADDR_W-1:0] addr;
		logic [BRAM_DATA_W-1:0] data;
		logic                   wr;
	} bram_port_t;

	// Sector request towards the host
	typedef struct packed {
		logic [LBA_W-1:0] lba;
		logic             rd;
		logic             wr;
	} sd_req_t;

	// Sector buffer traffic from the host
	typedef struct packed {
		logic [BUF_ADDR_W-1:0] addr;
		logic [BUF_DATA_W-1:0] dout;
		logic                  wr;
		logic                  ack;
	} sd_buf_t;

endpackage

// File: filelist.f
common/bk_pkg.sv
src/bk_sequencer.sv
src/sector_counter.sv
backup_ram/bram_format.sv
backup_ram/backup_ram.sv
src/bk_top.sv
tests/tb_bk_top.sv

// File: src/bk_sequencer.sv
/*
 * Save/load sequencer for the backup RAM.
 * Starts a transfer on a rising load or save command while a save file
 * is mounted, requests one host sector at a time and steps the sector
 * counter on every falling ack until the last sector is done.
 * Also tracks console writes not yet saved.
 */

`timescale 1ns/100ps

module bk_sequencer (
	input  logic clk_sys,
	input  logic reset,
	input  logic save_enable,
	input  logic cmd_load,
	input  logic cmd_save,
	input  logic console_wr,
	input  logic sd_ack,
	input  logic last_sector,
	output logic sector_clear,
	output logic sector_next,
	output logic sd_rd,
	output logic sd_wr,
	output logic busy,
	output logic loading,
	output logic pending
);

	typedef enum logic {
		S_IDLE,
		S_XFER
	} state_t;

	state_t state;

	logic old_load;
	logic old_save;
	logic old_ack;

	logic load_rise;
	logic save_rise;
	logic ack_rise;
	logic ack_fall;
	logic start;
	logic finish;

	////////////////////////////////////////
	// Edge detection
	////////////////////////////////////////

	assign load_rise = cmd_load & ~old_load;
	assign save_rise = cmd_save & ~old_save;
	assign ack_rise  = sd_ack & ~old_ack;
	assign ack_fall  = ~sd_ack & old_ack;

	// Only a mounted save file may start a transfer
	assign start  = (state == S_IDLE) & save_enable & (load_rise | save_rise);
	assign finish = (state == S_XFER) & ack_fall & last_sector;

	assign sector_clear = start | finish;
	assign sector_next  = (state == S_XFER) & ack_fall & ~last_sector;
	assign busy         = (state == S_XFER);

	////////////////////////////////////////
	// Transfer FSM
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= S_IDLE;
			loading  <= 1'b0;
			sd_rd    <= 1'b0;
			sd_wr    <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
		end else begin
			old_load <= cmd_load;
			old_save <= cmd_save;
			old_ack  <= sd_ack;

			// Host took the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				S_IDLE: begin
					if (start) begin
						state   <= S_XFER;
						// Load wins when both commands rise together
						loading <= load_rise;
						sd_rd   <= load_rise;
						sd_wr   <= ~load_rise;
					end
				end
				S_XFER: begin
					if (ack_fall) begin
						if (last_sector) begin
							state   <= S_IDLE;
							loading <= 1'b0;
						end else begin
							sd_rd <= loading;
							sd_wr <= ~loading;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Unsaved console writes, cleared once a transfer runs
	always_ff @(posedge clk_sys) begin
		if (reset)
			pending <= 1'b0;
		else if (console_wr && save_enable)
			pending <= 1'b1;
		else if (busy)
			pending <= 1'b0;
	end

	// Host sees one direction at a time
	a_one_dir: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr));

	// A request only exists inside a transfer
	a_req_busy: assert property (@(posedge clk_sys) disable iff (reset)
		!busy |-> !(sd_rd || sd_wr));

endmodule

// File: src/bk_top.sv
/*
 * Backup RAM subsystem top level.
 * Ties the save/load sequencer, the sector counter, the format writer and
 * the dual-width RAM to the console byte port and the host sector link.
 * N_SECTORS sets how many host sectors one save or load moves.
 */

`timescale 1ns/100ps

module bk_top import bk_pkg::*; #(
	parameter int N_SECTORS = N_SECTORS_DEF
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  bram_port_t             console,
	input  logic                   save_enable,
	input  logic                   cmd_load,
	input  logic                   cmd_save,
	input  logic                   cmd_format,
	input  sd_buf_t                sd_buf,
	output logic [BRAM_DATA_W-1:0] bram_q,
	output sd_req_t                sd_req,
	output logic [BUF_DATA_W-1:0]  sd_buff_din,
	output logic                   busy,
	output logic                   loading,
	output logic                   pending
);

	logic [LBA_W-1:0] lba;
	logic             sd_rd;
	logic             sd_wr;
	logic             sector_clear;
	logic             sector_next;
	logic             last_sector;

	logic                         fmt_active;
	logic [$clog2(HDR_WORDS)-1:0] fmt_addr;
	hdr_word_t                    fmt_data;

	logic [SECTOR_IDX_W+BUF_ADDR_W-1:0] host_addr;
	logic                               host_we;

	assign sd_req = '{lba: lba, rd: sd_rd, wr: sd_wr};

	// Sector index sits above the word offset
	assign host_addr = {lba[SECTOR_IDX_W-1:0], sd_buf.addr};
	assign host_we   = sd_buf.wr & sd_buf.ack;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	bk_sequencer i_sequencer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.save_enable  (save_enable),
		.cmd_load     (cmd_load),
		.cmd_save     (cmd_save),
		.console_wr   (console.wr),
		.sd_ack       (sd_buf.ack),
		.last_sector  (last_sector),
		.sector_clear (sector_clear),
		.sector_next  (sector_next),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.busy         (busy),
		.loading      (loading),
		.pending      (pending)
	);

	sector_counter #(
		.N_SECTORS (N_SECTORS)
	) i_sector_counter (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.clear       (sector_clear),
		.next        (sector_next),
		.lba         (lba),
		.last_sector (last_sector)
	);

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	bram_format i_bram_format (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cmd_format (cmd_format),
		.fmt_active (fmt_active),
		.fmt_addr   (fmt_addr),
		.fmt_data   (fmt_data)
	);

	backup_ram i_backup_ram (
		.clk_sys    (clk_sys),
		.console    (console),
		.host_addr  (host_addr),
		.host_din   (sd_buf.dout),
		.host_we    (host_we),
		.fmt_active (fmt_active),
		.fmt_addr   (fmt_addr),
		.fmt_data   (fmt_data),
		.bram_q     (bram_q),
		.host_q     (sd_buff_din)
	);

endmodule

// File: src/sector_counter.sv
/*
 * Host sector address for the save/load sequencer.
 * Cleared at the start and end of a transfer, stepped once per
 * completed sector, and flags the last sector of the save file.
 */

`timescale 1ns/100ps

module sector_counter import bk_pkg::*; #(
	parameter int N_SECTORS = N_SECTORS_DEF
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             clear,
	input  logic             next,
	output logic [LBA_W-1:0] lba,
	output logic             last_sector
);

	localparam logic [LBA_W-1:0] LAST_LBA = LBA_W'(N_SECTORS - 1);

	always_ff @(posedge clk_sys) begin
		if (reset)
			lba <= '0;
		else if (clear)
			lba <= '0;
		else if (next)
			lba <= lba + LBA_W'(1);
	end

	assign last_sector = (lba == LAST_LBA);

	// Sequencer must stop stepping at the last sector
	a_lba_range: assert property (@(posedge clk_sys) disable iff (reset)
		lba <= LAST_LBA);

endmodule

// File: tests/tb_bk_top.sv
/*
 * Testbench for the backup RAM subsystem top level.
 * Models the host sector link and runs directed tests for reset, console
 * access, format, save, load and an unmounted save. Prints one line per
 * test and a closing summary.
 */

`timescale 1ns/100ps

module tb_bk_top import bk_pkg::*; ();

	localparam int N_SECTORS = N_SECTORS_DEF;
	localparam int SECTOR_WORDS = 2 ** BUF_ADDR_W;
	localparam int RAM_BYTES = 2 ** BRAM_ADDR_W;
	localparam int WAIT_LIMIT = 2000;

	logic                   clk_sys;
	logic                   reset;
	bram_port_t             console;
	logic                   save_enable;
	logic                   cmd_load;
	logic                   cmd_save;
	logic                   cmd_format;
	sd_buf_t                sd_buf;
	logic [BRAM_DATA_W-1:0] bram_q;
	sd_req_t                sd_req;
	logic [BUF_DATA_W-1:0]  sd_buff_din;
	logic                   busy;
	logic                   loading;
	logic                   pending;

	// Expected RAM contents and the words the host sends on a load
	logic [BRAM_DATA_W-1:0] ram_model [RAM_BYTES];
	logic [BUF_DATA_W-1:0]  load_words [N_SECTORS*SECTOR_WORDS];

	int errors;
	int checks;
	int tests;
	int test_mark;

	bk_top #(.N_SECTORS(N_SECTORS)) i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_byte(input string name, input logic [BRAM_DATA_W-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input logic [BUF_DATA_W-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_req(input string name, input sd_req_t got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_mark)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: failed with %0d errors", tests, name, errors - test_mark);
		test_mark = errors;
	endtask

	////////////////////////////////////////
	// Console and host models
	////////////////////////////////////////

	task automatic write_byte(input int addr, input logic [BRAM_DATA_W-1:0] data);
		console = '{addr: BRAM_ADDR_W'(addr), data: data, wr: 1'b1};
		ram_model[addr] = data;
		@(negedge clk_sys);
		console.wr = 1'b0;
	endtask

	// bram_q follows the address one clock later
	task automatic expect_console_byte(input int addr);
		console.addr = BRAM_ADDR_W'(addr);
		console.wr = 1'b0;
		@(negedge clk_sys);
		check_byte($sformatf("bram_q[%0h]", addr), bram_q, ram_model[addr]);
	endtask

	task automatic pulse_command(input int which);
		cmd_load = (which == 0);
		cmd_save = (which == 1);
		cmd_format = (which == 2);
		@(negedge clk_sys);
		{cmd_load, cmd_save, cmd_format} = '0;
		@(negedge clk_sys);
	endtask

	// One sector of host traffic with ack held high for all 256 words
	task automatic serve_sector(input int lba, input bit is_load);
		sd_req_t exp_req;
		int idx;
		int count;
		count = 0;
		while (!(sd_req.rd || sd_req.wr) && count < WAIT_LIMIT) begin
			@(negedge clk_sys);
			count++;
		end
		if (!(sd_req.rd || sd_req.wr)) begin
			errors++;
			$display("Timed out waiting for the request of sector %0d", lba);
			return;
		end
		exp_req = '{lba: LBA_W'(lba), rd: is_load, wr: !is_load};
		check_req("sd_req", sd_req, exp_req);
		sd_buf.ack = 1'b1;
		sd_buf.addr = '0;
		for (int i = 0; i < SECTOR_WORDS; i++) begin
			idx = lba * SECTOR_WORDS + i;
			if (is_load) begin
				sd_buf.addr = BUF_ADDR_W'(i);
				sd_buf.dout = load_words[idx];
				sd_buf.wr = 1'b1;
				@(negedge clk_sys);
				check_bit("loading", loading, 1'b1);
			end else begin
				@(negedge clk_sys);
				check_word("sd_buff_din", sd_buff_din,
					{ram_model[2*idx+1], ram_model[2*idx]});
				sd_buf.addr = BUF_ADDR_W'(i + 1);
			end
		end
		sd_buf.wr = 1'b0;
		sd_buf.ack = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic wait_idle();
		int count;
		count = 0;
		while (busy && count < WAIT_LIMIT) begin
			@(negedge clk_sys);
			count++;
		end
		if (busy) begin
			errors++;
			$display("Timed out waiting for busy to fall");
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_reset_state();
		check_bit("busy", busy, 1'b0);
		check_bit("loading", loading, 1'b0);
		check_bit("pending", pending, 1'b0);
		check_req("sd_req", sd_req, '0);
		end_test("reset state");
	endtask

	task automatic test_console_rw();
		int addrs [16];
		save_enable = 1'b1;
		foreach (addrs[i]) begin
			addrs[i] = $urandom % RAM_BYTES;
			write_byte(addrs[i], BRAM_DATA_W'($urandom));
		end
		foreach (addrs[i])
			expect_console_byte(addrs[i]);
		check_bit("pending", pending, 1'b1);
		end_test("console write and read");
	endtask

	task automatic test_format();
		logic [BRAM_DATA_W-1:0] hdr [8] = '{8'h48, 8'h55, 8'h42, 8'h4D,
			8'h00, 8'h88, 8'h10, 8'h80};
		pulse_command(2);
		repeat (5) @(negedge clk_sys);
		for (int i = 0; i < 8; i++) begin
			ram_model[i] = hdr[i];
			expect_console_byte(i);
		end
		end_test("format header");
	endtask

	task automatic test_save();
		save_enable = 1'b1;
		for (int a = 0; a < RAM_BYTES; a++)
			write_byte(a, BRAM_DATA_W'($urandom));
		pulse_command(1);
		for (int s = 0; s < N_SECTORS; s++)
			serve_sector(s, 1'b0);
		wait_idle();
		check_bit("busy", busy, 1'b0);
		check_bit("pending", pending, 1'b0);
		check_req("sd_req", sd_req, '0);
		end_test("save");
	endtask

	task automatic test_load();
		foreach (load_words[w])
			load_words[w] = BUF_DATA_W'($urandom);
		pulse_command(0);
		for (int s = 0; s < N_SECTORS; s++)
			serve_sector(s, 1'b1);
		wait_idle();
		check_bit("busy", busy, 1'b0);
		check_bit("loading", loading, 1'b0);
		// Low byte of each word is the even address
		foreach (load_words[w]) begin
			ram_model[2*w] = load_words[w][7:0];
			ram_model[2*w+1] = load_words[w][15:8];
		end
		for (int a = 0; a < RAM_BYTES; a++)
			expect_console_byte(a);
		end_test("load");
	endtask

	task automatic test_unmounted_save();
		bit seen_req;
		seen_req = 1'b0;
		save_enable = 1'b0;
		pulse_command(1);
		for (int i = 0; i < 200 && !seen_req; i++) begin
			seen_req = sd_req.rd || sd_req.wr;
			check_bit("busy", busy, 1'b0);
			@(negedge clk_sys);
		end
		if (seen_req) begin
			errors++;
			$display("A sector request was raised while no save file was mounted");
		end
		end_test("save while unmounted");
	endtask

	initial begin
		int seed;
		seed = $urandom(32'hffd8_805e);
		reset = 1'b1;
		console = '0;
		save_enable = 1'b0;
		{cmd_load, cmd_save, cmd_format} = '0;
		sd_buf = '0;
		@(posedge clk_sys);
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		test_reset_state();
		test_console_rw();
		test_format();
		test_save();
		test_load();
		test_unmounted_save();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
